/* src/exec_pkg.sv */
package exec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and fixed constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN   = 64;                     // data word
  localparam int ILEN   = 32;                     // instruction word
  localparam int PREG_W = 6;                      // physical register index

  localparam logic [PREG_W-1:0] ZERO_REG = 31;   // no writeback

  // instruction field widths, alpha layout
  localparam int OPCODE_W   = 6;
  localparam int REG_W      = 5;
  localparam int LIT_W      = 8;
  localparam int MEM_DISP_W = ILEN - OPCODE_W - 2 * REG_W;   // 16
  localparam int BR_DISP_W  = ILEN - OPCODE_W - REG_W;       // 21

  localparam int MULT_STAGES = 4;
  localparam int MULT_SLICE  = XLEN / MULT_STAGES;   // multiplier bits per stage

  localparam logic [XLEN-1:0] OPB_POISON = 64'hbaad_beef_dead_beef;
  localparam logic [XLEN-1:0] NOT3_MASK  = {{(XLEN-2){1'b1}}, 2'b00};  // word-aligned jumps

  ////////////////////////////////////////////////////////////////////////////
  // decoder selects and function codes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ALU_OPA_IS_REGA     = 2'h0,
    ALU_OPA_IS_MEM_DISP = 2'h1,
    ALU_OPA_IS_NPC      = 2'h2,
    ALU_OPA_IS_NOT3     = 2'h3
  } opa_sel_t;

  typedef enum logic [1:0] {
    ALU_OPB_IS_REGB    = 2'h0,
    ALU_OPB_IS_ALU_IMM = 2'h1,
    ALU_OPB_IS_BR_DISP = 2'h2
  } opb_sel_t;                                    // 2'h3 left unused

  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,
    ALU_SUBQ   = 5'h01,
    ALU_AND    = 5'h02,
    ALU_BIS    = 5'h04,
    ALU_XOR    = 5'h06,
    ALU_SRL    = 5'h08,
    ALU_SLL    = 5'h09,
    ALU_SRA    = 5'h0a,
    ALU_CMPEQ  = 5'h0c,
    ALU_CMPLT  = 5'h0d,
    ALU_CMPLE  = 5'h0e,
    ALU_CMPULT = 5'h0f
  } alu_func_t;

  // low three opcode bits of a conditional branch, bit 2 inverts the test
  typedef enum logic [2:0] {
    BR_LBC = 3'b000,
    BR_EQ  = 3'b001,
    BR_LT  = 3'b010,
    BR_LE  = 3'b011,
    BR_LBS = 3'b100,
    BR_NE  = 3'b101,
    BR_GE  = 3'b110,
    BR_GT  = 3'b111
  } br_cond_t;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word, three views of the same 32 bits
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [OPCODE_W-1:0]   opcode;
    logic [REG_W-1:0]      ra;
    logic [REG_W-1:0]      rb;
    logic [MEM_DISP_W-1:0] disp;
  } mem_fmt_t;

  typedef struct packed {
    logic [OPCODE_W-1:0]  opcode;
    logic [REG_W-1:0]     ra;
    logic [BR_DISP_W-1:0] disp;
  } br_fmt_t;

  typedef struct packed {
    logic [OPCODE_W-1:0] opcode;
    logic [REG_W-1:0]    ra;
    logic [LIT_W-1:0]    lit;                     // bits 20:13
    logic                lit_flag;
    logic [6:0]          func;
    logic [REG_W-1:0]    rc;
  } op_fmt_t;

  typedef union packed {
    mem_fmt_t mem;
    br_fmt_t  br;
    op_fmt_t  op;
  } inst_word_t;

endpackage

/* src/exec_operand_if.sv */
`timescale 1ns/1ps

interface exec_operand_if
  import exec_pkg::*;
();

  logic [XLEN-1:0]   opa;                         // selected operand a
  logic [XLEN-1:0]   opb;                         // selected operand b
  logic [XLEN-1:0]   npc;                         // pc + 4 of the instruction
  logic [PREG_W-1:0] dest_reg_idx;
  logic              valid;

  // operand selector side
  modport src (
    output opa, opb, npc, dest_reg_idx, valid
  );

  // alu, writeback and multiplier side
  modport dst (
    input opa, opb, npc, dest_reg_idx, valid
  );

endinterface

/* src/operand_select.sv */
`timescale 1ns/1ps

module operand_select
  import exec_pkg::*;
(
  input  logic [XLEN-1:0]   npc,
  input  inst_word_t        ir,
  input  logic [XLEN-1:0]   rega,
  input  logic [XLEN-1:0]   regb,
  input  opa_sel_t          opa_select,
  input  opb_sel_t          opb_select,
  input  logic [PREG_W-1:0] dest_reg_idx,
  input  logic              valid,
  exec_operand_if.src       ops
);

  logic [XLEN-1:0] mem_disp;
  logic [XLEN-1:0] br_disp;
  logic [XLEN-1:0] alu_imm;

  // immediates pulled from the instruction word
  assign mem_disp = {{(XLEN-MEM_DISP_W){ir.mem.disp[MEM_DISP_W-1]}}, ir.mem.disp};
  assign br_disp  = {{(XLEN-BR_DISP_W-2){ir.br.disp[BR_DISP_W-1]}},
                     ir.br.disp, 2'b00};          // word offset to bytes
  assign alu_imm  = {{(XLEN-LIT_W){1'b0}}, ir.op.lit};   // literal is unsigned

  // operand a mux
  always_comb
  begin
    ops.opa = rega;
    case (opa_select)
      ALU_OPA_IS_REGA:     ops.opa = rega;
      ALU_OPA_IS_MEM_DISP: ops.opa = mem_disp;
      ALU_OPA_IS_NPC:      ops.opa = npc;
      ALU_OPA_IS_NOT3:     ops.opa = NOT3_MASK;
    endcase
  end

  // operand b mux
  always_comb
  begin
    case (opb_select)
      ALU_OPB_IS_REGB:    ops.opb = regb;
      ALU_OPB_IS_ALU_IMM: ops.opb = alu_imm;
      ALU_OPB_IS_BR_DISP: ops.opb = br_disp;
      default:            ops.opb = OPB_POISON;  // easy to spot in a dump
    endcase
  end

  // tags ride along with the operands
  assign ops.npc          = npc;
  assign ops.dest_reg_idx = dest_reg_idx;
  assign ops.valid        = valid;

endmodule

/* src/alu_core.sv */
`timescale 1ns/1ps

module alu_core
  import exec_pkg::*;
(
  exec_operand_if.dst     ops,
  input  alu_func_t       func,
  output logic [XLEN-1:0] result
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic signed [XLEN-1:0]    opa_s;               // signed views for sra and compares
  logic signed [XLEN-1:0]    opb_s;
  logic        [SHAMT_W-1:0] shamt;
  logic                      lt_signed;
  logic                      lt_unsigned;
  logic                      equal;

  assign opa_s = ops.opa;
  assign opb_s = ops.opb;
  assign shamt = ops.opb[SHAMT_W-1:0];          // only low bits count

  assign lt_signed   = (opa_s < opb_s);
  assign lt_unsigned = (ops.opa < ops.opb);
  assign equal       = (ops.opa == ops.opb);

  ////////////////////////////////////////////////////////////////////////////
  // function select
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (func)
      ALU_ADDQ:
        result = ops.opa + ops.opb;
      ALU_SUBQ:
        result = ops.opa - ops.opb;
      ALU_AND:
        result = ops.opa & ops.opb;
      ALU_BIS:
        result = ops.opa | ops.opb;
      ALU_XOR:
        result = ops.opa ^ ops.opb;
      ALU_SLL:
        result = ops.opa << shamt;
      ALU_SRL:
        result = ops.opa >> shamt;              // zero fill
      ALU_SRA:
        result = opa_s >>> shamt;               // sign fill
      ALU_CMPEQ:
        result = {{(XLEN-1){1'b0}}, equal};
      ALU_CMPLT:
        result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_CMPLE:
        result = {{(XLEN-1){1'b0}}, lt_signed | equal};
      ALU_CMPULT:
        result = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:
        result = OPB_POISON;                    // undecoded function
    endcase
  end

endmodule

/* src/alu_writeback.sv */
`timescale 1ns/1ps

module alu_writeback
  import exec_pkg::*;
(
  exec_operand_if.dst       ops,
  input  inst_word_t        ir,
  input  logic [XLEN-1:0]   rega,
  input  logic [XLEN-1:0]   raw_result,
  input  logic              rd_mem,
  input  logic              wr_mem,
  input  logic              cond_branch,
  input  logic              uncond_branch,
  output logic [XLEN-1:0]   result,
  output logic [XLEN-1:0]   branch_target,
  output logic [XLEN-1:0]   store_data,
  output logic              take_branch,
  output logic              mem_read,
  output logic              mem_write,
  output logic [PREG_W-1:0] dest_reg_idx
);

  br_cond_t cond;
  logic     rega_zero;
  logic     rega_neg;
  logic     cond_true;

  assign cond      = br_cond_t'(ir.br.opcode[2:0]);
  assign rega_zero = (rega == '0);
  assign rega_neg  = rega[XLEN-1];

  // branch condition on register a
  always_comb
  begin
    cond_true = 1'b0;
    case (cond)
      BR_LBC: cond_true = ~rega[0];
      BR_EQ:  cond_true = rega_zero;
      BR_LT:  cond_true = rega_neg;
      BR_LE:  cond_true = rega_neg | rega_zero;
      BR_LBS: cond_true = rega[0];
      BR_NE:  cond_true = ~rega_zero;
      BR_GE:  cond_true = ~rega_neg;
      BR_GT:  cond_true = ~rega_neg & ~rega_zero;
    endcase
  end

  assign take_branch = ops.valid & (uncond_branch | (cond_branch & cond_true));

  // link value replaces the adder output on jumps and unconditional branches
  assign result        = !ops.valid   ? '0 :
                         uncond_branch ? ops.npc :
                                         raw_result;
  assign branch_target = ops.valid ? raw_result : '0;   // adder computes the target

  assign mem_read  = ops.valid & rd_mem;
  assign mem_write = ops.valid & wr_mem;

  // loads and stores write back through the lsq, not here
  assign dest_reg_idx = (rd_mem | wr_mem) ? ZERO_REG : ops.dest_reg_idx;
  assign store_data   = rega;

endmodule

/* src/mult_pipeline.sv */
`timescale 1ns/1ps

module mult_pipeline
  import exec_pkg::*;
(
  input  logic              clock,
  input  logic              rst_n,
  exec_operand_if.dst       ops,
  output logic [XLEN-1:0]   product,
  output logic              valid,
  output logic [XLEN-1:0]   npc,
  output logic [PREG_W-1:0] dest_reg_idx
);

  logic [XLEN-1:0]   sum_in    [MULT_STAGES+1];   // running sum entering each stage
  logic [XLEN-1:0]   mcand_in  [MULT_STAGES];
  logic [XLEN-1:0]   mplier_in [MULT_STAGES];
  logic              valid_q   [MULT_STAGES];
  logic [XLEN-1:0]   npc_q     [MULT_STAGES];
  logic [PREG_W-1:0] dest_q    [MULT_STAGES];

  assign sum_in[0]    = '0;
  assign mcand_in[0]  = ops.opb;
  assign mplier_in[0] = ops.opa;

  ////////////////////////////////////////////////////////////////////////////
  // partial product stages
  ////////////////////////////////////////////////////////////////////////////

  for (genvar s = 0; s < MULT_STAGES; s++) begin : g_stage
    logic [XLEN-1:0] pprod;
    logic [XLEN-1:0] sum_q;

    // multiplicand times the next slice of the multiplier
    assign pprod = mcand_in[s] * {{(XLEN-MULT_SLICE){1'b0}}, mplier_in[s][MULT_SLICE-1:0]};

    always_ff @(posedge clock or negedge rst_n)
    begin
      if (!rst_n)
        sum_q <= '0;
      else
        sum_q <= sum_in[s] + pprod;
    end

    assign sum_in[s+1] = sum_q;

    if (s < MULT_STAGES - 1) begin : g_carry
      logic [XLEN-1:0] mcand_q;
      logic [XLEN-1:0] mplier_q;

      always_ff @(posedge clock or negedge rst_n)
      begin
        if (!rst_n)
        begin
          mcand_q  <= '0;
          mplier_q <= '0;
        end
        else
        begin
          mcand_q  <= mcand_in[s] << MULT_SLICE;    // weight of the next slice
          mplier_q <= mplier_in[s] >> MULT_SLICE;   // consumed bits drop off
        end
      end

      assign mcand_in[s+1]  = mcand_q;
      assign mplier_in[s+1] = mplier_q;
    end
  end

  // tags follow their product through the stages
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < MULT_STAGES; s++)
      begin
        valid_q[s] <= 1'b0;
        npc_q[s]   <= '0;
        dest_q[s]  <= '0;
      end
    end
    else
    begin
      valid_q[0] <= ops.valid;
      npc_q[0]   <= ops.npc;
      dest_q[0]  <= ops.dest_reg_idx;
      for (int s = 1; s < MULT_STAGES; s++)
      begin
        valid_q[s] <= valid_q[s-1];
        npc_q[s]   <= npc_q[s-1];
        dest_q[s]  <= dest_q[s-1];
      end
    end
  end

  assign product      = sum_in[MULT_STAGES];   // low xlen bits only
  assign valid        = valid_q[MULT_STAGES-1];
  assign npc          = npc_q[MULT_STAGES-1];
  assign dest_reg_idx = dest_q[MULT_STAGES-1];

endmodule

/* src/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
  import exec_pkg::*;
(
  input  logic              clock,
  input  logic              rst_n,

  // alu lane
  input  logic [XLEN-1:0]   alu_npc,
  input  inst_word_t        alu_ir,
  input  logic [XLEN-1:0]   alu_rega,
  input  logic [XLEN-1:0]   alu_regb,
  input  logic [PREG_W-1:0] alu_dest_reg_idx,
  input  opa_sel_t          alu_opa_select,
  input  opb_sel_t          alu_opb_select,
  input  alu_func_t         alu_func,
  input  logic              alu_rd_mem,
  input  logic              alu_wr_mem,
  input  logic              alu_cond_branch,
  input  logic              alu_uncond_branch,
  input  logic              alu_valid,

  // multiply lane
  input  logic [XLEN-1:0]   mult_npc,
  input  inst_word_t        mult_ir,
  input  logic [XLEN-1:0]   mult_rega,
  input  logic [XLEN-1:0]   mult_regb,
  input  logic [PREG_W-1:0] mult_dest_reg_idx,
  input  opa_sel_t          mult_opa_select,
  input  opb_sel_t          mult_opb_select,
  input  logic              mult_valid,

  output logic [XLEN-1:0]   wb_alu_npc,
  output logic [XLEN-1:0]   wb_alu_result,
  output logic [XLEN-1:0]   wb_alu_branch_target,
  output logic              wb_alu_take_branch,
  output logic              wb_alu_rd_mem,
  output logic              wb_alu_wr_mem,
  output logic              wb_alu_valid,
  output logic [PREG_W-1:0] wb_alu_dest_reg_idx,
  output logic [XLEN-1:0]   wb_alu_store_data,

  output logic [XLEN-1:0]   wb_mult_npc,
  output logic [XLEN-1:0]   wb_mult_result,
  output logic              wb_mult_valid,
  output logic [PREG_W-1:0] wb_mult_dest_reg_idx
);

  exec_operand_if alu_ops ();
  exec_operand_if mult_ops ();

  logic [XLEN-1:0] alu_raw_result;   // adder output before link/valid muxing

  ////////////////////////////////////////////////////////////////////////////
  // alu lane, combinational
  ////////////////////////////////////////////////////////////////////////////

  operand_select alu_sel (
    .npc          (alu_npc),
    .ir           (alu_ir),
    .rega         (alu_rega),
    .regb         (alu_regb),
    .opa_select   (alu_opa_select),
    .opb_select   (alu_opb_select),
    .dest_reg_idx (alu_dest_reg_idx),
    .valid        (alu_valid),
    .ops          (alu_ops.src)
  );

  alu_core alu0 (
    .ops    (alu_ops.dst),
    .func   (alu_func),
    .result (alu_raw_result)
  );

  alu_writeback alu_wb (
    .ops           (alu_ops.dst),
    .ir            (alu_ir),
    .rega          (alu_rega),
    .raw_result    (alu_raw_result),
    .rd_mem        (alu_rd_mem),
    .wr_mem        (alu_wr_mem),
    .cond_branch   (alu_cond_branch),
    .uncond_branch (alu_uncond_branch),
    .result        (wb_alu_result),
    .branch_target (wb_alu_branch_target),
    .store_data    (wb_alu_store_data),
    .take_branch   (wb_alu_take_branch),
    .mem_read      (wb_alu_rd_mem),
    .mem_write     (wb_alu_wr_mem),
    .dest_reg_idx  (wb_alu_dest_reg_idx)
  );

  assign wb_alu_npc   = alu_ops.npc;
  assign wb_alu_valid = alu_ops.valid;

  ////////////////////////////////////////////////////////////////////////////
  // multiply lane, MULT_STAGES cycles
  ////////////////////////////////////////////////////////////////////////////

  operand_select mult_sel (
    .npc          (mult_npc),
    .ir           (mult_ir),
    .rega         (mult_rega),
    .regb         (mult_regb),
    .opa_select   (mult_opa_select),
    .opb_select   (mult_opb_select),
    .dest_reg_idx (mult_dest_reg_idx),
    .valid        (mult_valid),
    .ops          (mult_ops.src)
  );

  mult_pipeline mult0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .ops          (mult_ops.dst),
    .product      (wb_mult_result),
    .valid        (wb_mult_valid),
    .npc          (wb_mult_npc),
    .dest_reg_idx (wb_mult_dest_reg_idx)
  );

endmodule

/* verification/exec_stage_tb.sv */
`timescale 1ns/1ps

module exec_stage_tb
  import exec_pkg::*;
();

  typedef struct {
    alu_func_t         func;
    logic [1:0]        opa_sel;
    logic [1:0]        opb_sel;
    logic [ILEN-1:0]   ir;
    logic [XLEN-1:0]   rega;
    logic [XLEN-1:0]   regb;
    logic [4:0]        flags;                     // valid, rd, wr, cond, uncond
    logic [XLEN-1:0]   exp_result;
    logic [XLEN-1:0]   exp_target;
    logic              exp_take;
  } alu_row_t;

  typedef struct {
    logic [XLEN-1:0]   product;
    logic [XLEN-1:0]   npc;
    logic [PREG_W-1:0] dest;
    int                due;                       // edge count when it must show up
  } mult_exp_t;

  logic clock;
  logic rst_n;
  logic [XLEN-1:0]   alu_npc, alu_rega, alu_regb;
  inst_word_t        alu_ir;
  logic [PREG_W-1:0] alu_dest_reg_idx;
  opa_sel_t          alu_opa_select;
  opb_sel_t          alu_opb_select;
  alu_func_t         alu_func;
  logic              alu_rd_mem, alu_wr_mem, alu_cond_branch, alu_uncond_branch, alu_valid;
  logic [XLEN-1:0]   mult_npc, mult_rega, mult_regb;
  inst_word_t        mult_ir;
  logic [PREG_W-1:0] mult_dest_reg_idx;
  opa_sel_t          mult_opa_select;
  opb_sel_t          mult_opb_select;
  logic              mult_valid;
  logic [XLEN-1:0]   wb_alu_npc, wb_alu_result, wb_alu_branch_target, wb_alu_store_data;
  logic              wb_alu_take_branch, wb_alu_rd_mem, wb_alu_wr_mem, wb_alu_valid;
  logic [PREG_W-1:0] wb_alu_dest_reg_idx;
  logic [XLEN-1:0]   wb_mult_npc, wb_mult_result;
  logic              wb_mult_valid;
  logic [PREG_W-1:0] wb_mult_dest_reg_idx;

  alu_row_t    tbl[$];
  mult_exp_t   pending[$];                        // products still in the pipeline
  logic        tbl_ready = 1'b0;
  logic [31:0] lfsr = 32'h44aa3ddf;
  int          edge_count = 0;
  int          reset_cycles = 10;
  int          rand_count = 40;                   // multiply slots, issue or gap

  exec_stage UUT (.*);

  always #2 clock = ~clock;

  always @(posedge clock)
    edge_count <= edge_count + 1;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [XLEN-1:0] random_bits(input int n);
    logic [XLEN-1:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = next_lfsr(lfsr);
      v = {v[XLEN-2:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic add_row(input alu_func_t func, input logic [1:0] opa_sel,
                         input logic [1:0] opb_sel, input logic [ILEN-1:0] ir,
                         input logic [XLEN-1:0] rega, input logic [XLEN-1:0] regb,
                         input logic [4:0] flags, input logic [XLEN-1:0] exp_result,
                         input logic [XLEN-1:0] exp_target, input logic exp_take);
    alu_row_t r;
    r = '{func, opa_sel, opb_sel, ir, rega, regb, flags, exp_result, exp_target, exp_take};
    tbl.push_back(r);
  endtask

  // npc is 64'h1000 and the destination is 7 on every row
  task automatic build_table();
    add_row(ALU_ADDQ, 2'd0, 2'd0, 32'h0, 64'd5, 64'd7, 5'b10000, 64'd12, 64'd12, 1'b0);
    add_row(ALU_SUBQ, 2'd0, 2'd0, 32'h0, 64'd5, 64'd7, 5'b10000, -64'd2, -64'd2, 1'b0);
    add_row(ALU_AND, 2'd0, 2'd0, 32'h0, 64'hf0f0, 64'h0ff0, 5'b10000, 64'hf0, 64'hf0, 1'b0);
    add_row(ALU_BIS, 2'd0, 2'd0, 32'h0, 64'hf000, 64'hf, 5'b10000, 64'hf00f, 64'hf00f, 1'b0);
    add_row(ALU_XOR, 2'd0, 2'd0, 32'h0, 64'hff00, 64'h0ff0, 5'b10000, 64'hf0f0, 64'hf0f0, 1'b0);
    add_row(ALU_SLL, 2'd0, 2'd0, 32'h0, 64'd1, 64'd68, 5'b10000, 64'h10, 64'h10, 1'b0);
    add_row(ALU_SRL, 2'd0, 2'd0, 32'h0, -64'd16, 64'd4, 5'b10000, 64'h0fffffffffffffff,
            64'h0fffffffffffffff, 1'b0);
    add_row(ALU_SRA, 2'd0, 2'd0, 32'h0, -64'd16, 64'd4, 5'b10000, -64'd1, -64'd1, 1'b0);
    add_row(ALU_CMPEQ, 2'd0, 2'd0, 32'h0, 64'd9, 64'd9, 5'b10000, 64'd1, 64'd1, 1'b0);
    add_row(ALU_CMPEQ, 2'd0, 2'd0, 32'h0, 64'd9, 64'd8, 5'b10000, 64'd0, 64'd0, 1'b0);
    add_row(ALU_CMPLT, 2'd0, 2'd0, 32'h0, -64'd1, 64'd1, 5'b10000, 64'd1, 64'd1, 1'b0);
    add_row(ALU_CMPLT, 2'd0, 2'd0, 32'h0, 64'd2, 64'd1, 5'b10000, 64'd0, 64'd0, 1'b0);
    add_row(ALU_CMPLE, 2'd0, 2'd0, 32'h0, 64'd3, 64'd3, 5'b10000, 64'd1, 64'd1, 1'b0);
    add_row(ALU_CMPLE, 2'd0, 2'd0, 32'h0, 64'd4, 64'd3, 5'b10000, 64'd0, 64'd0, 1'b0);
    add_row(ALU_CMPULT, 2'd0, 2'd0, 32'h0, -64'd1, 64'd1, 5'b10000, 64'd0, 64'd0, 1'b0);
    add_row(ALU_CMPULT, 2'd0, 2'd0, 32'h0, 64'd1, -64'd1, 5'b10000, 64'd1, 64'd1, 1'b0);
    // operand selection: literal, npc, not3 mask, unused b code
    add_row(ALU_ADDQ, 2'd0, 2'd1, 32'h001fe000, 64'd1, 64'd0, 5'b10000, 64'h100, 64'h100, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd0, 32'h0, 64'd0, 64'd4, 5'b10000, 64'h1004, 64'h1004, 1'b0);
    add_row(ALU_AND, 2'd3, 2'd0, 32'h0, 64'd0, 64'h1237, 5'b10000, 64'h1234, 64'h1234, 1'b0);
    add_row(ALU_AND, 2'd0, 2'd3, 32'h0, -64'd1, 64'd0, 5'b10000, 64'hbaadbeefdeadbeef,
            64'hbaadbeefdeadbeef, 1'b0);
    // loads and stores, displacement -16 and +8
    add_row(ALU_ADDQ, 2'd1, 2'd0, 32'h0000fff0, 64'h55, 64'h100, 5'b11000, 64'hf0, 64'hf0, 1'b0);
    add_row(ALU_ADDQ, 2'd1, 2'd0, 32'h8, 64'hdeadbeef, 64'h200, 5'b10100, 64'h208, 64'h208, 1'b0);
    add_row(ALU_ADDQ, 2'd1, 2'd0, 32'h0000fff0, 64'h55, 64'h100, 5'b01000, 64'd0, 64'd0, 1'b0);
    add_row(ALU_ADDQ, 2'd1, 2'd0, 32'h8, 64'hdeadbeef, 64'h200, 5'b00100, 64'd0, 64'd0, 1'b0);
    // conditional branches, a true and a false rega each
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'he0000010, 64'd2, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'he0000010, 64'd1, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'he41ffffc, 64'd0, 64'd0, 5'b10010, 64'hff0, 64'hff0, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'he41ffffc, 64'd5, 64'd0, 5'b10010, 64'hff0, 64'hff0, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'he8000010, -64'd1, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'he8000010, 64'd0, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hec000010, 64'd0, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hec000010, 64'd1, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hf0000010, 64'd3, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hf0000010, 64'd4, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hf4000010, 64'd1, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hf4000010, 64'd0, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hf8000010, 64'd0, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hf8000010, -64'd1, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b0);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hfc000010, 64'd1, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hfc000010, 64'd0, 64'd0, 5'b10010, 64'h1040, 64'h1040, 1'b0);
    // unconditional branch links npc, then idle rows
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hc0000010, 64'd0, 64'd0, 5'b10001, 64'h1000, 64'h1040, 1'b1);
    add_row(ALU_ADDQ, 2'd2, 2'd2, 32'hc0000010, 64'd0, 64'd0, 5'b00001, 64'd0, 64'd0, 1'b0);
    add_row(ALU_ADDQ, 2'd0, 2'd0, 32'h0, 64'd5, 64'd7, 5'b00000, 64'd0, 64'd0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // multiply lane checker, runs for the whole test
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clock)
  begin : mult_monitor
    mult_exp_t head;
    logic      due_now;
    due_now = (pending.size() > 0) && (pending[0].due == edge_count);
    check_value(wb_mult_valid, due_now, "wb_mult_valid");
    if (wb_mult_valid)
    begin
      head = pending.pop_front();
      check_value(wb_mult_result, head.product, "wb_mult_result");
      check_value(wb_mult_npc, head.npc, "wb_mult_npc");
      check_value(wb_mult_dest_reg_idx, head.dest, "wb_mult_dest_reg_idx");
    end
  end

  initial
  begin : watchdog
    wait (tbl_ready);
    #((reset_cycles + tbl.size() + rand_count + MULT_STAGES) * 4 * 2);
    $display("Timeout: the multiply results did not all arrive in time");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    alu_row_t        r;
    mult_exp_t       e;
    logic [XLEN-1:0] opa_val;
    logic [XLEN-1:0] opb_val;
    clock = 1'b0;
    rst_n = 1'b0;
    alu_npc = 64'h1000;
    alu_ir = 32'h0;
    alu_rega = 64'd5;                             // nonzero so idle gating shows
    alu_regb = 64'd7;
    alu_dest_reg_idx = 6'd7;
    alu_opa_select = ALU_OPA_IS_REGA;
    alu_opb_select = ALU_OPB_IS_REGB;
    alu_func = ALU_ADDQ;
    alu_rd_mem = 1'b1;
    alu_wr_mem = 1'b1;
    alu_cond_branch = 1'b0;
    alu_uncond_branch = 1'b1;
    alu_valid = 1'b0;
    mult_npc = '0;
    mult_ir = 32'h0;
    mult_rega = '0;
    mult_regb = '0;
    mult_dest_reg_idx = '0;
    mult_opa_select = ALU_OPA_IS_REGA;
    mult_opb_select = ALU_OPB_IS_REGB;
    mult_valid = 1'b0;
    build_table();
    tbl_ready = 1'b1;

    for (int c = 0; c < reset_cycles; c++)
    begin
      @(negedge clock);
      check_value(wb_alu_result, 64'd0, "idle wb_alu_result");
      check_value(wb_alu_branch_target, 64'd0, "idle wb_alu_branch_target");
      check_value(wb_alu_take_branch, 1'b0, "idle wb_alu_take_branch");
      check_value(wb_alu_rd_mem, 1'b0, "idle wb_alu_rd_mem");
      check_value(wb_alu_wr_mem, 1'b0, "idle wb_alu_wr_mem");
    end
    @(posedge clock);
    rst_n <= 1'b1;

    for (int i = 0; i < tbl.size(); i++)
    begin
      r = tbl[i];
      @(posedge clock);
      alu_func <= r.func;
      alu_opa_select <= opa_sel_t'(r.opa_sel);
      alu_opb_select <= opb_sel_t'(r.opb_sel);
      alu_ir <= r.ir;
      alu_rega <= r.rega;
      alu_regb <= r.regb;
      {alu_valid, alu_rd_mem, alu_wr_mem, alu_cond_branch, alu_uncond_branch} <= r.flags;
      @(negedge clock);                           // lane is combinational
      check_value(wb_alu_result, r.exp_result, $sformatf("row %0d result", i));
      check_value(wb_alu_branch_target, r.exp_target, $sformatf("row %0d target", i));
      check_value(wb_alu_take_branch, r.exp_take, $sformatf("row %0d take_branch", i));
      check_value(wb_alu_rd_mem, r.flags[4] & r.flags[3], $sformatf("row %0d rd_mem", i));
      check_value(wb_alu_wr_mem, r.flags[4] & r.flags[2], $sformatf("row %0d wr_mem", i));
      check_value(wb_alu_dest_reg_idx, (r.flags[3] | r.flags[2]) ? 6'd31 : 6'd7,
                  $sformatf("row %0d dest_reg_idx", i));
      check_value(wb_alu_store_data, r.rega, $sformatf("row %0d store_data", i));
      check_value(wb_alu_npc, 64'h1000, $sformatf("row %0d npc", i));
      check_value(wb_alu_valid, r.flags[4], $sformatf("row %0d valid", i));
    end

    for (int n = 0; n < rand_count; n++)
    begin
      @(posedge clock);
      alu_valid <= 1'b0;
      if (random_bits(2) == 0)
      begin
        mult_valid <= 1'b0;                       // gap slot
      end
      else
      begin
        opa_val = random_bits(XLEN);
        opb_val = random_bits(XLEN);
        e.npc = random_bits(XLEN);
        e.dest = PREG_W'(random_bits(PREG_W));
        e.product = opa_val * opb_val;            // low word of the full product
        e.due = edge_count + 1 + MULT_STAGES;     // this edge plus the stages
        mult_rega <= opa_val;
        mult_regb <= opb_val;
        mult_npc <= e.npc;
        mult_dest_reg_idx <= e.dest;
        mult_valid <= 1'b1;
        pending.push_back(e);
      end
    end
    @(posedge clock);
    mult_valid <= 1'b0;
    while (pending.size() != 0)
      @(negedge clock);
    @(negedge clock);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* compile.f */
src/exec_pkg.sv
src/exec_operand_if.sv
src/operand_select.sv
src/alu_core.sv
src/alu_writeback.sv
src/mult_pipeline.sv
src/exec_stage.sv
verification/exec_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_TEXT ?= Test completed successfully

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
